/* dv/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb;

   import tomasulo_pkg::*;

   localparam int NUM_RS      = 4;
   localparam int ACK_LIMIT   = 500;
   localparam int IDLE_ROUNDS = 200;

   logic        clk;
   logic        rst_n;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [7:0]  adr;
   logic [31:0] dat_w;
   logic        ack;
   logic [31:0] dat_r;

   logic [31:0] model_regs [32];   // program order view of the registers
   logic [31:0] written;            // registers that wait_idle has to poll
   logic [31:0] prog_q [$];
   string       test_name;
   int          test_errors;
   int          total_errors;
   int          tests_run;
   int          tests_failed;
   int          checks;
   int          max_ack_wait;
   int          stalled_writes;
   bit          timed_out;

   ooo_core_top #(.NUM_RS(NUM_RS)) uut (
      .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .ack, .dat_r
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] encode(input logic [2:0] op, input int rd, input int rs,
                                          input int rt, input logic [13:0] imm);
      return {op, 5'(rd), 5'(rs), 5'(rt), imm};
   endfunction

   function automatic void model_apply(input logic [31:0] word);
      logic [4:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      rd = word[28:24];
      a  = model_regs[word[23:19]];
      b  = model_regs[word[18:14]];
      case (word[31:29])
         // two's complement value of the 14 bit field
         LI:      res = word[13] ? (32'(word[13:0]) - 32'h0000_4000) : 32'(word[13:0]);
         ADD:     res = a + b;
         SUB:     res = a - b;
         AND:     res = a & b;
         OR:      res = a | b;
         XOR:     res = a ^ b;
         default: res = '0;
      endcase
      if (rd != 5'd0) begin
         model_regs[rd] = res;
         written[rd]    = 1'b1;
      end
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Wishbone driver
   //////////////////////////////////////////////////////////////////////

   task automatic wait_ack(output bit ok, output int waited);
      waited = 0;
      ok     = 1'b0;
      while (!ok && waited < ACK_LIMIT) begin
         @(negedge clk);   // ack is stable away from the rising edge
         waited++;
         if (ack) begin
            ok = 1'b1;
         end
      end
      if (!ok) begin
         $display("ERROR: %s saw no ack within %0d cycles", test_name, ACK_LIMIT);
         timed_out = 1'b1;
      end
   endtask

   task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
      bit ok;
      int waited;
      data = '0;
      if (timed_out) begin
         return;
      end
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= addr;
      wait_ack(ok, waited);
      data = dat_r;
      if (ok) begin
         checks++;
         if (waited != 2) begin   // a read is answered one cycle after stb
            report_mismatch("read ack latency", 32'd2, 32'(waited));
         end
      end
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   // writes every queued instruction with stb held from one transfer to the next
   task automatic issue_program();
      bit ok;
      int waited;
      foreach (prog_q[i]) begin
         if (timed_out) begin
            break;
         end
         @(posedge clk);
         cyc   <= 1'b1;
         stb   <= 1'b1;
         we    <= 1'b1;
         adr   <= 8'h00;
         dat_w <= prog_q[i];
         wait_ack(ok, waited);
         if (ok) begin
            model_apply(prog_q[i]);
            checks++;
            if (waited < 2) begin
               $display("ERROR: %s got a write ack in the same cycle stb rose", test_name);
               test_errors++;
            end
            if (waited > max_ack_wait) begin
               max_ack_wait = waited;
            end
            if (waited > 2) begin
               stalled_writes++;
            end
         end
      end
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
      prog_q.delete();
   endtask

   task automatic wb_write(input logic [31:0] word);
      prog_q.push_back(word);
      issue_program();
   endtask

   task automatic wait_idle();
      logic [31:0] st;
      bit          busy;
      int          rounds;
      rounds = 0;
      busy   = 1'b1;
      while (busy && !timed_out) begin
         busy = 1'b0;
         for (int r = 1; r < 32; r++) begin
            if (written[r]) begin
               wb_read(8'hA0 | 8'(r), st);
               if (st[6]) begin
                  busy = 1'b1;
               end
            end
         end
         rounds++;
         if (busy && rounds >= IDLE_ROUNDS) begin
            $display("ERROR: %s registers still busy after %0d polls", test_name, rounds);
            timed_out = 1'b1;
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // bookkeeping
   //////////////////////////////////////////////////////////////////////

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
      tests_run++;
   endtask

   task automatic finish_test();
      total_errors += test_errors;
      if (test_errors != 0) begin
         tests_failed++;
      end
      $display("test %s done, %0d errors", test_name, test_errors);
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
      test_errors++;
   endtask

   task automatic check_regs();
      logic [31:0] val;
      for (int r = 0; r < 32; r++) begin
         wb_read(8'h80 | 8'(r), val);
         checks++;
         if (val !== model_regs[r]) begin
            report_mismatch($sformatf("r%0d", r), model_regs[r], val);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_reset();
      logic [31:0] val;
      start_test("reset");
      check_regs();
      for (int r = 0; r < 32; r++) begin
         wb_read(8'hA0 | 8'(r), val);
         checks++;
         if (val[6] !== 1'b0) begin
            report_mismatch($sformatf("status busy of r%0d", r), 32'd0, {31'd0, val[6]});
         end
      end
      finish_test();
   endtask

   task automatic test_load_immediates();
      start_test("load_immediates");
      prog_q.push_back(encode(LI, 1, 0, 0, 14'h0001));
      prog_q.push_back(encode(LI, 2, 0, 0, 14'h3fff));   // minus one
      prog_q.push_back(encode(LI, 3, 0, 0, 14'h2000));
      prog_q.push_back(encode(LI, 4, 0, 0, 14'h1fff));
      prog_q.push_back(encode(LI, 0, 0, 0, 14'h0123));
      prog_q.push_back(encode(LI, 31, 0, 0, 14'h2abc));
      issue_program();
      wb_write(encode(LI, 0, 0, 0, 14'h3fff));
      wait_idle();
      check_regs();
      finish_test();
   endtask

   task automatic test_dependency_chain();
      start_test("dependency_chain");
      prog_q.push_back(encode(LI, 1, 0, 0, 14'd100));
      prog_q.push_back(encode(LI, 2, 0, 0, 14'd7));
      prog_q.push_back(encode(ADD, 3, 1, 2, 14'd0));
      prog_q.push_back(encode(SUB, 4, 3, 2, 14'd0));
      prog_q.push_back(encode(AND, 5, 4, 3, 14'd0));
      prog_q.push_back(encode(OR, 6, 5, 1, 14'd0));
      prog_q.push_back(encode(XOR, 7, 6, 4, 14'd0));
      prog_q.push_back(encode(SUB, 8, 2, 7, 14'd0));
      issue_program();
      wait_idle();
      check_regs();
      finish_test();
   endtask

   task automatic test_write_after_write();
      start_test("write_after_write");
      prog_q.push_back(encode(LI, 9, 0, 0, 14'h0055));
      prog_q.push_back(encode(ADD, 10, 9, 1, 14'd0));   // must see the first r9
      prog_q.push_back(encode(LI, 9, 0, 0, 14'h3f00));
      issue_program();
      wait_idle();
      check_regs();
      finish_test();
   endtask

   task automatic test_burst();
      logic [2:0] op;
      start_test("burst");
      max_ack_wait   = 0;
      stalled_writes = 0;
      for (int i = 0; i < 3 * NUM_RS; i++) begin
         op = (i % 3 == 0) ? LI : ((i % 3 == 1) ? ADD : XOR);
         prog_q.push_back(encode(op, 11 + (i % 6), 11 + ((i + 5) % 6),
                                 (i % 2 == 1) ? 1 : 11 + ((i + 4) % 6), 14'(i * 37)));
      end
      issue_program();
      $display("burst: longest ack wait %0d cycles, %0d writes stalled",
               max_ack_wait, stalled_writes);
      wait_idle();
      check_regs();
      finish_test();
   endtask

   task automatic test_random();
      start_test("random");
      for (int i = 0; i < 50; i++) begin
         prog_q.push_back(encode(3'($urandom % 6), int'($urandom % 8), int'($urandom % 8),
                                 int'($urandom % 8), 14'($urandom)));
      end
      issue_program();
      wait_idle();
      check_regs();
      finish_test();
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h88cd_9ac1));
      cyc          = 1'b0;
      stb          = 1'b0;
      we           = 1'b0;
      adr          = 8'h00;
      dat_w        = 32'd0;
      rst_n        = 1'b0;
      written      = 32'd0;
      total_errors = 0;
      tests_run    = 0;
      tests_failed = 0;
      checks       = 0;
      timed_out    = 1'b0;
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = 32'd0;
      end

      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      if (!timed_out) test_reset();
      if (!timed_out) test_load_immediates();
      if (!timed_out) test_dependency_chain();
      if (!timed_out) test_write_after_write();
      if (!timed_out) test_burst();
      if (!timed_out) test_random();

      $display("tests %0d, failed %0d, checks %0d, errors %0d, timeout %0d",
               tests_run, tests_failed, checks, total_errors, timed_out);
      if (total_errors == 0 && !timed_out) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* rtl/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
   input  logic                   clk,
   input  logic                   rst_n,
   input  tomasulo_pkg::alu_req_t alu_req,
   output tomasulo_pkg::cdb_t     cdb
);

   import tomasulo_pkg::*;

   data_t result;
   logic  cdb_valid_q;
   tag_t  cdb_tag_q;
   data_t cdb_data_q;

   always_comb begin
      case (alu_req.op)
         LI:      result = alu_req.a;   // immediate already sits in operand a
         ADD:     result = alu_req.a + alu_req.b;
         SUB:     result = alu_req.a - alu_req.b;
         AND:     result = alu_req.a & alu_req.b;
         OR:      result = alu_req.a | alu_req.b;
         XOR:     result = alu_req.a ^ alu_req.b;
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cdb_valid_q <= 1'b0;
      end else begin
         cdb_valid_q <= alu_req.valid;   // one broadcast per request
      end
   end

   always_ff @(posedge clk) begin
      if (alu_req.valid) begin
         cdb_tag_q  <= alu_req.tag;
         cdb_data_q <= result;
      end
   end

   always_comb begin
      cdb.valid = cdb_valid_q;
      cdb.tag   = cdb_tag_q;
      cdb.data  = cdb_data_q;
   end

endmodule

/* rtl/dispatch_stage.sv */
`timescale 1ns/1ps

module dispatch_stage #(
   parameter int NUM_RS = 4
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     cyc,
   input  logic                     stb,
   input  logic                     we,
   input  logic [7:0]               adr,
   input  tomasulo_pkg::data_t      dat_w,
   output logic                     ack,
   output tomasulo_pkg::data_t      dat_r,
   input  tomasulo_pkg::rst_entry_t rs_entry,
   input  tomasulo_pkg::rst_entry_t rt_entry,
   input  tomasulo_pkg::data_t      rs_data,
   input  tomasulo_pkg::data_t      rt_data,
   input  tomasulo_pkg::data_t      host_rdata,
   input  tomasulo_pkg::rst_entry_t host_status,
   input  tomasulo_pkg::cdb_t       cdb,
   input  logic                     full,
   input  tomasulo_pkg::tag_t       free_tag,
   output tomasulo_pkg::reg_addr_t  rs_addr,
   output tomasulo_pkg::reg_addr_t  rt_addr,
   output tomasulo_pkg::reg_addr_t  host_addr,
   output logic                     rename_en,
   output tomasulo_pkg::reg_addr_t  rename_rd,
   output tomasulo_pkg::tag_t       rename_tag,
   output logic                     push,
   output tomasulo_pkg::rs_entry_t  push_entry
);

   import tomasulo_pkg::*;

   typedef enum logic {IDLE, ACK} ack_state_e;

   ack_state_e state_q;
   instr_t     instr;
   logic       wr_instr;
   logic       slot_ok;
   logic       accept;

   function automatic operand_t fetch_operand(input reg_addr_t  addr,
                                              input rst_entry_t st,
                                              input data_t      rf_data,
                                              input cdb_t       bus);
      operand_t opnd;
      opnd.ready = 1'b1;
      opnd.tag   = '0;
      opnd.data  = rf_data;
      if (addr == '0) begin
         opnd.data = '0;
      end else if (st.busy) begin
         if (bus.valid && (bus.tag == st.tag)) begin
            opnd.data = bus.data;   // producer is on the bus right now
         end else begin
            opnd.ready = 1'b0;
            opnd.tag   = st.tag;
            opnd.data  = '0;
         end
      end
      return opnd;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // decode and rename
   //////////////////////////////////////////////////////////////////////

   assign instr     = instr_t'(dat_w);
   assign rs_addr   = instr.rs;
   assign rt_addr   = instr.rt;
   assign host_addr = adr[4:0];

   assign wr_instr = cyc && stb && we && !adr[7];
   assign slot_ok  = !full && (free_tag != '0) && (int'(free_tag) <= NUM_RS);
   assign push     = (state_q == IDLE) && wr_instr && slot_ok;

   assign rename_en  = push && (instr.rd != '0);
   assign rename_rd  = instr.rd;
   assign rename_tag = free_tag;

   always_comb begin
      push_entry.op = instr.op;
      if (instr.op == LI) begin
         push_entry.a = '{ready: 1'b1, tag: '0, data: {{18{instr.imm[13]}}, instr.imm}};
         push_entry.b = '{ready: 1'b1, tag: '0, data: '0};
      end else begin
         push_entry.a = fetch_operand(instr.rs, rs_entry, rs_data, cdb);
         push_entry.b = fetch_operand(instr.rt, rt_entry, rt_data, cdb);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Wishbone handshake
   //////////////////////////////////////////////////////////////////////

   // anything but an instruction write is taken at once
   assign accept = (state_q == IDLE) && cyc && stb && (wr_instr ? slot_ok : 1'b1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= IDLE;
      end else if (state_q == ACK) begin
         state_q <= IDLE;
      end else if (accept) begin
         state_q <= ACK;
      end
   end

   assign ack = (state_q == ACK);

   always_ff @(posedge clk) begin
      if (accept && !we) begin
         if (adr[7] && adr[5]) begin
            dat_r <= {25'b0, host_status};
         end else if (adr[7]) begin
            dat_r <= host_rdata;
         end else begin
            dat_r <= '0;
         end
      end
   end

endmodule

/* rtl/ooo_core_top.sv */
`timescale 1ns/1ps

module ooo_core_top #(
   parameter int NUM_RS = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                cyc,
   input  logic                stb,
   input  logic                we,
   input  logic [7:0]          adr,
   input  tomasulo_pkg::data_t dat_w,
   output logic                ack,
   output tomasulo_pkg::data_t dat_r
);

   import tomasulo_pkg::*;

   reg_addr_t   rs_addr;
   reg_addr_t   rt_addr;
   reg_addr_t   host_addr;
   rst_entry_t  rs_entry;
   rst_entry_t  rt_entry;
   rst_entry_t  host_status;
   data_t       rs_data;
   data_t       rt_data;
   data_t       host_rdata;
   logic        rename_en;
   reg_addr_t   rename_rd;
   tag_t        rename_tag;
   logic        push;
   rs_entry_t   push_entry;
   logic        full;
   tag_t        free_tag;
   alu_req_t    alu_req;
   cdb_t        cdb;
   logic [31:0] wen_regfile;

   dispatch_stage #(.NUM_RS(NUM_RS)) u_dispatch (
      .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .ack, .dat_r,
      .rs_entry, .rt_entry, .rs_data, .rt_data, .host_rdata, .host_status,
      .cdb, .full, .free_tag, .rs_addr, .rt_addr, .host_addr,
      .rename_en, .rename_rd, .rename_tag, .push, .push_entry
   );

   reg_status_table u_rst (
      .clk, .rst_n, .rename_en, .rename_rd, .rename_tag,
      .rs_addr, .rt_addr, .host_addr, .cdb,
      .rs_entry, .rt_entry, .host_status, .wen_regfile
   );

   register_file u_regfile (
      .clk, .rst_n, .rs_addr, .rt_addr, .host_addr, .wen_regfile, .cdb,
      .rs_data, .rt_data, .host_rdata
   );

   reservation_station #(.NUM_RS(NUM_RS)) u_rs (
      .clk, .rst_n, .push, .push_entry, .cdb, .full, .free_tag, .alu_req
   );

   alu_unit u_alu (
      .clk, .rst_n, .alu_req, .cdb
   );

endmodule

/* rtl/reg_status_table.sv */
`timescale 1ns/1ps

module reg_status_table (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     rename_en,
   input  tomasulo_pkg::reg_addr_t  rename_rd,
   input  tomasulo_pkg::tag_t       rename_tag,
   input  tomasulo_pkg::reg_addr_t  rs_addr,
   input  tomasulo_pkg::reg_addr_t  rt_addr,
   input  tomasulo_pkg::reg_addr_t  host_addr,
   input  tomasulo_pkg::cdb_t       cdb,
   output tomasulo_pkg::rst_entry_t rs_entry,
   output tomasulo_pkg::rst_entry_t rt_entry,
   output tomasulo_pkg::rst_entry_t host_status,
   output logic [31:0]              wen_regfile
);

   import tomasulo_pkg::*;

   rst_entry_t status_q [32];
   rst_entry_t status_d [32];

   //////////////////////////////////////////////////////////////////////
   // next state: CDB clear first, then rename on top
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < 32; i++) begin
         status_d[i]    = status_q[i];
         wen_regfile[i] = 1'b0;

         if (status_q[i].busy && cdb.valid && (cdb.tag == status_q[i].tag)) begin
            status_d[i]    = '0;
            wen_regfile[i] = 1'b1;   // the producer of this register has finished
         end

         // a new producer wins over a finishing old one
         if (rename_en && (rename_rd == reg_addr_t'(i))) begin
            status_d[i].busy = 1'b1;
            status_d[i].tag  = rename_tag;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            status_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 32; i++) begin
            status_q[i] <= status_d[i];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read ports
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      rs_entry    = status_q[rs_addr];
      rt_entry    = status_q[rt_addr];
      host_status = status_q[host_addr];   // host sees the state after the last edge
   end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
   input  logic                    clk,
   input  logic                    rst_n,
   input  tomasulo_pkg::reg_addr_t rs_addr,
   input  tomasulo_pkg::reg_addr_t rt_addr,
   input  tomasulo_pkg::reg_addr_t host_addr,
   input  logic [31:0]             wen_regfile,
   input  tomasulo_pkg::cdb_t      cdb,
   output tomasulo_pkg::data_t     rs_data,
   output tomasulo_pkg::data_t     rt_data,
   output tomasulo_pkg::data_t     host_rdata
);

   import tomasulo_pkg::*;

   data_t regs_q [32];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         for (int i = 1; i < 32; i++) begin   // r0 is never written
            if (cdb.valid && wen_regfile[i]) begin
               regs_q[i] <= cdb.data;
            end
         end
      end
   end

   always_comb begin
      rs_data    = (rs_addr == '0)   ? '0 : regs_q[rs_addr];
      rt_data    = (rt_addr == '0)   ? '0 : regs_q[rt_addr];
      host_rdata = (host_addr == '0) ? '0 : regs_q[host_addr];
   end

endmodule

/* rtl/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station #(
   parameter int NUM_RS = 4
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    push,
   input  tomasulo_pkg::rs_entry_t push_entry,
   input  tomasulo_pkg::cdb_t      cdb,
   output logic                    full,
   output tomasulo_pkg::tag_t      free_tag,
   output tomasulo_pkg::alu_req_t  alu_req
);

   import tomasulo_pkg::*;

   rs_entry_t         entry_q [NUM_RS];
   logic [NUM_RS-1:0] valid_q;
   logic [NUM_RS-1:0] issued_q;
   logic [NUM_RS-1:0] older_q [NUM_RS];   // older_q[j][i] set when j came in before i
   logic [NUM_RS-1:0] ready;
   logic [NUM_RS-1:0] pick;
   logic [NUM_RS-1:0] release_vec;
   int                free_idx;

   //////////////////////////////////////////////////////////////////////
   // free slot and oldest ready pick
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      full     = &valid_q;
      free_idx = 0;
      free_tag = '0;
      for (int i = NUM_RS - 1; i >= 0; i--) begin
         if (!valid_q[i]) begin
            free_idx = i;
            free_tag = tag_t'(i + 1);
         end
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_RS; i++) begin
         ready[i] = valid_q[i] && !issued_q[i] && entry_q[i].a.ready && entry_q[i].b.ready;
         release_vec[i] = cdb.valid && (cdb.tag == tag_t'(i + 1));
      end
      for (int i = 0; i < NUM_RS; i++) begin
         pick[i] = ready[i];
         for (int j = 0; j < NUM_RS; j++) begin
            if ((j != i) && ready[j] && older_q[j][i]) begin
               pick[i] = 1'b0;   // an older entry is ready too
            end
         end
      end
   end

   always_comb begin
      alu_req = '0;
      for (int i = 0; i < NUM_RS; i++) begin
         if (pick[i]) begin
            alu_req.valid = 1'b1;
            alu_req.op    = entry_q[i].op;
            alu_req.tag   = tag_t'(i + 1);
            alu_req.a     = entry_q[i].a.data;
            alu_req.b     = entry_q[i].b.data;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // entry state
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q  <= '0;
         issued_q <= '0;
         for (int i = 0; i < NUM_RS; i++) begin
            older_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_RS; i++) begin
            if (push && (free_idx == i)) begin
               valid_q[i]  <= 1'b1;
               issued_q[i] <= 1'b0;
            end else if (release_vec[i]) begin
               valid_q[i]  <= 1'b0;   // tag is free again once its result is out
               issued_q[i] <= 1'b0;
            end else if (pick[i]) begin
               issued_q[i] <= 1'b1;
            end
         end
         if (push) begin
            for (int j = 0; j < NUM_RS; j++) begin
               older_q[free_idx][j] <= 1'b0;
               older_q[j][free_idx] <= (j != free_idx);   // newcomer is youngest
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_RS; i++) begin
         if (push && (free_idx == i)) begin
            entry_q[i] <= push_entry;
         end else begin
            if (!entry_q[i].a.ready && cdb.valid && (cdb.tag == entry_q[i].a.tag)) begin
               entry_q[i].a.ready <= 1'b1;
               entry_q[i].a.data  <= cdb.data;
            end
            if (!entry_q[i].b.ready && cdb.valid && (cdb.tag == entry_q[i].b.tag)) begin
               entry_q[i].b.ready <= 1'b1;
               entry_q[i].b.data  <= cdb.data;
            end
         end
      end
   end

endmodule

/* rtl/tomasulo_pkg.sv */
package tomasulo_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths with a meaning
   //////////////////////////////////////////////////////////////////////

   typedef logic [4:0]  reg_addr_t;   // architectural register index
   typedef logic [5:0]  tag_t;        // station entry index plus one, 0 is no producer
   typedef logic [31:0] data_t;
   typedef logic [13:0] imm_t;

   typedef enum logic [2:0] {
      LI  = 3'd0,
      ADD = 3'd1,
      SUB = 3'd2,
      AND = 3'd3,
      OR  = 3'd4,
      XOR = 3'd5
   } opcode_e;

   //////////////////////////////////////////////////////////////////////
   // bundles
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic busy;
      tag_t tag;
   } rst_entry_t;

   typedef struct packed {
      opcode_e   op;
      reg_addr_t rd;
      reg_addr_t rs;
      reg_addr_t rt;
      imm_t      imm;   // sign extended for LI
   } instr_t;

   typedef struct packed {
      logic  ready;
      tag_t  tag;
      data_t data;
   } operand_t;

   typedef struct packed {
      opcode_e  op;
      operand_t a;
      operand_t b;
   } rs_entry_t;

   typedef struct packed {
      logic  valid;
      tag_t  tag;
      data_t data;
   } cdb_t;

   typedef struct packed {
      logic    valid;
      opcode_e op;
      tag_t    tag;
      data_t   a;
      data_t   b;
   } alu_req_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it into a log and checks the log.

BUILD_DIR=obj_dir
SIM_BIN=ooo_core_sim
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
   --top-module ooo_core_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
   exit 0
else
   echo "no pass line found in $LOG"
   exit 1
fi

/* sources.f */
rtl/tomasulo_pkg.sv
rtl/reg_status_table.sv
rtl/register_file.sv
rtl/dispatch_stage.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/ooo_core_top.sv
dv/ooo_core_tb.sv
